//--- bench/link_chk.sv
`default_nettype none

`include "link_consts.svh"

module link_chk #(
	parameter int BUS_WIDTH = `LINK_BUS_WIDTH
) (
	input wire logic                 clk,
	input wire logic                 rst_n,
	input wire logic                 send,
	input wire link_pkg::tx_state_t  state,
	input wire logic [BUS_WIDTH-1:0] beat,
	input wire logic                 beat_valid,
	input wire logic                 beat_last,
	input wire logic                 beat_ready
);

	int xfer_cnt;

	// transfers already done in the current word.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xfer_cnt <= 0;
		end else if (beat_valid && beat_ready) begin
			xfer_cnt <= beat_last ? 0 : xfer_cnt + 1;
		end
	end

	//////////////////////////////
	// beat bus rules
	//////////////////////////////

	stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		beat_valid && !beat_ready |=> beat_valid && $stable(beat) && $stable(beat_last))
		else $error("beat bus changed while stalled");

	last_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		beat_last |-> beat_valid)
		else $error("beat_last high without beat_valid");

	// the bus stays quiet until the transmitter takes a word.
	quiet_until_send: assert property (@(posedge clk) disable iff (!rst_n)
		!beat_valid && !(send && state == link_pkg::tx_idle) |=> !beat_valid)
		else $error("beat_valid rose without an accepted send");

	last_on_final: assert property (@(posedge clk) disable iff (!rst_n)
		beat_valid && beat_ready && beat_last |-> xfer_cnt == `LINK_BEATS - 1)
		else $error("beat_last did not mark the final beat of the word");

endmodule

bind word_transmit link_chk #(.BUS_WIDTH(BUS_WIDTH)) u_chk (
	.clk        (clk),
	.rst_n      (rst_n),
	.send       (send),
	.state      (state),
	.beat       (beat),
	.beat_valid (beat_valid),
	.beat_last  (beat_last),
	.beat_ready (beat_ready)
);

`default_nettype wire

//--- bench/link_tb.sv
`default_nettype none

`include "link_consts.svh"

module link_tb;

	localparam int DW      = `LINK_DATA_WIDTH;
	localparam int BW      = `LINK_BUS_WIDTH;
	localparam int TIMEOUT = 4000;

	logic               clk;
	logic               rst_n;
	logic      [DW-1:0] data_to_send;
	logic               send;
	logic               dev_rdy;
	logic               stall_en;
	wire logic          busy;
	wire logic [DW-1:0] data;
	wire logic          valid_data;

	logic [DW-1:0] exp_q[$];
	int            accept_cnt = 0;
	int            pulse_cnt = 0;
	int            cycle_cnt = 0;

	link_top #(
		.DATA_WIDTH (DW),
		.BUS_WIDTH  (BW)
	) u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.data_to_send (data_to_send),
		.send         (send),
		.busy         (busy),
		.dev_rdy      (dev_rdy),
		.data         (data),
		.valid_data   (valid_data)
	);

	always #4 clk = ~clk;

	// the word is cut into beats lsb first and put back together in bus order.
	function automatic logic [DW-1:0] link_model(input logic [DW-1:0] word);
		logic [BW-1:0] beats [`LINK_BEATS];
		logic [DW-1:0] rebuilt;
		rebuilt = '0;
		for (int i = 0; i < `LINK_BEATS; i++) begin
			beats[i] = word[i*BW +: BW];
		end
		for (int i = 0; i < `LINK_BEATS; i++) begin
			rebuilt[i*BW +: BW] = beats[i];
		end
		return rebuilt;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [DW-1:0] expected,
			input logic [DW-1:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("mismatch %s expected 0x%h actual 0x%h", name, expected, actual));
		end
	endtask

	task automatic check_quiet();
		check_value("busy", '0, DW'(busy));
		check_value("valid_data", '0, DW'(valid_data));
		check_value("data", '0, data);
	endtask

	// waits until the transmitter is idle, then strobes send for one cycle.
	task automatic send_word(input logic [DW-1:0] word);
		@(negedge clk);
		while (busy) begin
			@(negedge clk);
		end
		@(posedge clk);
		send         <= 1'b1;
		data_to_send <= word;
		@(posedge clk);
		send <= 1'b0;
	endtask

	task automatic drain();
		@(negedge clk);
		while (busy || exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	//////////////////////////////
	// monitor and compare
	//////////////////////////////

	// a send is taken only while busy is low.
	always @(posedge clk) begin
		if (rst_n && valid_data) begin
			pulse_cnt++;
			if (exp_q.size() == 0) begin
				abort_run("valid_data pulsed while no word was outstanding");
			end else begin
				check_value("data", exp_q.pop_front(), data);
			end
		end
		if (rst_n && send && !busy) begin
			exp_q.push_back(link_model(data_to_send));
			accept_cnt++;
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT) begin
			abort_run($sformatf("run did not finish within %0d cycles", TIMEOUT));
		end
	end

	// device back-pressure, low for 1 to 8 cycles at a time.
	initial begin
		dev_rdy <= 1'b1;
		forever begin
			@(posedge clk);
			if (stall_en) begin
				dev_rdy <= 1'b0;
				repeat ($urandom_range(1, 8)) @(posedge clk);
				dev_rdy <= 1'b1;
				repeat ($urandom_range(1, 8)) @(posedge clk);
			end
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial begin
		int pulses_before;
		void'($urandom(5553));
		clk          = 1'b0;
		stall_en     = 1'b0;
		rst_n        <= 1'b0;
		send         <= 1'b0;
		data_to_send <= '0;
		@(posedge clk);
		@(negedge clk);
		check_quiet();
		@(posedge clk);
		rst_n <= 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_quiet();
		end

		// unstalled, the word shows up one cycle after the last beat moves.
		send_word(32'h5a3c_96e1);
		for (int i = 0; i < `LINK_BEATS; i++) begin
			@(negedge clk);
			check_value("busy", DW'(1), DW'(busy));
			check_value("valid_data", '0, DW'(valid_data));
		end
		@(negedge clk);
		check_value("busy", '0, DW'(busy));
		check_value("valid_data", DW'(1), DW'(valid_data));
		check_value("data", link_model(32'h5a3c_96e1), data);
		@(negedge clk);
		check_value("valid_data", '0, DW'(valid_data));

		send_word(32'h0403_0201);
		send_word(32'h8040_2010);
		send_word(32'hddcc_bbaa);
		drain();

		// strobes during a word in flight must be dropped.
		pulses_before = pulse_cnt;
		send_word(32'h1234_5678);
		@(posedge clk);
		send         <= 1'b1;
		data_to_send <= 32'hdead_beef;
		@(posedge clk);
		data_to_send <= 32'hcafe_f00d;
		@(posedge clk);
		send <= 1'b0;
		drain();
		check_value("valid_data pulses", DW'(pulses_before + 1), DW'(pulse_cnt));

		@(negedge clk);
		stall_en = 1'b1;
		repeat (200) begin
			send_word($urandom());
		end
		@(negedge clk);
		stall_en = 1'b0;
		drain();

		repeat (2) @(negedge clk);
		if (exp_q.size() == 0 && pulse_cnt == accept_cnt) begin
			$display(">>> PASS");
			$finish;
		end else begin
			abort_run($sformatf("%0d words accepted but %0d delivered", accept_cnt, pulse_cnt));
		end
	end

endmodule

`default_nettype wire

//--- hdl/link_consts.svh
`ifndef LINK_CONSTS_SVH
`define LINK_CONSTS_SVH

//////////////////////////////
// link widths
//////////////////////////////

// width of one complete data word.
`define LINK_DATA_WIDTH 32

// width of one beat on the link.
`define LINK_BUS_WIDTH 8

// beats needed for one word at the default widths.
// the data width has to be a whole multiple of the bus width.
`define LINK_BEATS (`LINK_DATA_WIDTH / `LINK_BUS_WIDTH)

`endif

//--- hdl/link_pkg.sv
`default_nettype none

package link_pkg;

	//////////////////////////////
	// transmitter states
	//////////////////////////////

	// tx_idle holds no word, tx_beat is sending one.
	typedef enum logic {
		tx_idle = 1'b0,
		tx_beat = 1'b1
	} tx_state_t;

	//////////////////////////////
	// receiver states
	//////////////////////////////

	// rx_done lasts for the single cycle in which a word is announced.
	typedef enum logic {
		rx_collect = 1'b0,
		rx_done    = 1'b1
	} rx_state_t;

endpackage

`default_nettype wire

//--- hdl/link_top.sv
`default_nettype none

`include "link_consts.svh"

module link_top #(
	parameter int DATA_WIDTH = `LINK_DATA_WIDTH,
	parameter int BUS_WIDTH  = `LINK_BUS_WIDTH
) (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic [DATA_WIDTH-1:0] data_to_send,
	input  wire logic                  send,
	output wire logic                  busy,
	input  wire logic                  dev_rdy,
	output wire logic [DATA_WIDTH-1:0] data,
	output wire logic                  valid_data
);

	//////////////////////////////
	// beat bus
	//////////////////////////////

	wire logic [BUS_WIDTH-1:0] beat;
	wire logic                 beat_valid;
	wire logic                 beat_last;
	wire logic                 beat_ready;

	// the transmitter cuts each word into beats.
	word_transmit #(
		.DATA_WIDTH (DATA_WIDTH),
		.BUS_WIDTH  (BUS_WIDTH)
	) u_tx (
		.clk          (clk),
		.rst_n        (rst_n),
		.data_to_send (data_to_send),
		.send         (send),
		.beat_ready   (beat_ready),
		.busy         (busy),
		.beat         (beat),
		.beat_valid   (beat_valid),
		.beat_last    (beat_last)
	);

	// the receiver rebuilds the word for the device.
	word_receive #(
		.DATA_WIDTH (DATA_WIDTH),
		.BUS_WIDTH  (BUS_WIDTH)
	) u_rx (
		.clk        (clk),
		.rst_n      (rst_n),
		.dev_rdy    (dev_rdy),
		.beat       (beat),
		.beat_valid (beat_valid),
		.beat_last  (beat_last),
		.beat_ready (beat_ready),
		.data       (data),
		.valid_data (valid_data)
	);

endmodule

`default_nettype wire

//--- hdl/word_receive.sv
`default_nettype none

`include "link_consts.svh"

module word_receive #(
	parameter int DATA_WIDTH = `LINK_DATA_WIDTH,
	parameter int BUS_WIDTH  = `LINK_BUS_WIDTH
) (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic                  dev_rdy,
	input  wire logic [BUS_WIDTH-1:0]  beat,
	input  wire logic                  beat_valid,
	input  wire logic                  beat_last,
	output logic                       beat_ready,
	output logic      [DATA_WIDTH-1:0] data,
	output logic                       valid_data
);

	link_pkg::rx_state_t state;
	link_pkg::rx_state_t state_next;

	logic [DATA_WIDTH-1:0] asm_reg;
	logic [DATA_WIDTH-1:0] asm_next;
	logic                  beat_xfer;
	logic                  word_end;

	//////////////////////////////
	// handshake decode
	//////////////////////////////

	// ready comes from the device alone, never from beat_valid.
	assign beat_ready = dev_rdy;
	assign beat_xfer  = beat_valid && beat_ready;
	assign word_end   = beat_xfer && beat_last;

	//////////////////////////////
	// word assembly
	//////////////////////////////

	// new beats enter at the top and move down one slot per transfer.
	// after a full word the first beat sits in the least significant slot.
	always_comb begin
		asm_next = DATA_WIDTH'({beat, asm_reg} >> BUS_WIDTH);
	end

	always_ff @(posedge clk) begin
		if (beat_xfer) begin
			asm_reg <= asm_next;
		end
	end

	//////////////////////////////
	// state machine
	//////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			link_pkg::rx_collect: begin
				if (word_end) begin
					state_next = link_pkg::rx_done;
				end
			end
			link_pkg::rx_done: begin
				// a one beat word can finish again right away.
				if (word_end) begin
					state_next = link_pkg::rx_done;
				end else begin
					state_next = link_pkg::rx_collect;
				end
			end
			default: begin
				state_next = link_pkg::rx_collect;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= link_pkg::rx_collect;
		end else begin
			state <= state_next;
		end
	end

	//////////////////////////////
	// output word
	//////////////////////////////

	// data keeps the last word until the next one completes.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data <= '0;
		end else if (word_end) begin
			data <= asm_next;
		end
	end

	assign valid_data = (state == link_pkg::rx_done);

endmodule

`default_nettype wire

//--- hdl/word_transmit.sv
`default_nettype none

`include "link_consts.svh"

module word_transmit #(
	parameter int DATA_WIDTH = `LINK_DATA_WIDTH,
	parameter int BUS_WIDTH  = `LINK_BUS_WIDTH
) (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic [DATA_WIDTH-1:0] data_to_send,
	input  wire logic                  send,
	input  wire logic                  beat_ready,
	output logic                       busy,
	output logic      [BUS_WIDTH-1:0]  beat,
	output logic                       beat_valid,
	output logic                       beat_last
);

	localparam int BEATS = DATA_WIDTH / BUS_WIDTH;
	localparam int CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;

	link_pkg::tx_state_t state;
	link_pkg::tx_state_t state_next;

	logic [DATA_WIDTH-1:0] shift_reg;
	logic [CNT_W-1:0]      beat_cnt;
	logic                  take_word;
	logic                  beat_xfer;
	logic                  final_beat;

	//////////////////////////////
	// handshake decode
	//////////////////////////////

	// a send strobe only counts while no word is held.
	assign take_word  = send && (state == link_pkg::tx_idle);
	assign beat_xfer  = beat_valid && beat_ready;
	assign final_beat = (beat_cnt == CNT_W'(BEATS - 1));

	//////////////////////////////
	// state machine
	//////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			link_pkg::tx_idle: begin
				if (take_word) begin
					state_next = link_pkg::tx_beat;
				end
			end
			link_pkg::tx_beat: begin
				// leave on the edge that moves the last beat.
				if (beat_xfer && final_beat) begin
					state_next = link_pkg::tx_idle;
				end
			end
			default: begin
				state_next = link_pkg::tx_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= link_pkg::tx_idle;
		end else begin
			state <= state_next;
		end
	end

	//////////////////////////////
	// beat counter
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_cnt <= '0;
		end else if (take_word) begin
			beat_cnt <= '0;
		end else if (beat_xfer) begin
			if (final_beat) begin
				beat_cnt <= '0;
			end else begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////
	// word shift register
	//////////////////////////////

	// the low slice of the register is always the beat on the bus.
	// each transfer drops it and brings the next one down.
	always_ff @(posedge clk) begin
		if (take_word) begin
			shift_reg <= data_to_send;
		end else if (beat_xfer) begin
			shift_reg <= shift_reg >> BUS_WIDTH;
		end
	end

	//////////////////////////////
	// outputs
	//////////////////////////////

	assign busy       = (state == link_pkg::tx_beat);
	assign beat_valid = (state == link_pkg::tx_beat);
	assign beat_last  = beat_valid && final_beat;
	assign beat       = shift_reg[BUS_WIDTH-1:0];

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# builds the link testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f --top-module link_tb -o link_sim \
	&& ./obj_dir/link_sim 2>&1 | tee sim.log \
	|| echo "build or simulation stopped early"

grep -qsx '>>> PASS' sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- verilog.f
+incdir+hdl
hdl/link_pkg.sv
hdl/word_transmit.sv
hdl/word_receive.sv
hdl/link_top.sv
bench/link_chk.sv
bench/link_tb.sv
